// ==== include/dma_consts.svh ====
// --------------------------------------
// DMA copy engine widths and queue depths
// --------------------------------------
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// one data beat and its beat address
`define DMA_DATA_W      64
`define DMA_ADDR_W      16

// descriptor length, counted in beats
`define DMA_LENGTH_W    12

// burst length field, so 16 beats per burst at most
`define DMA_BURST_LEN_W 4

// queue depths
`define DMA_DESC_DEPTH  4
`define DMA_DATA_DEPTH  32

// leaves room for the push pipeline and beats in flight
`define DMA_DATA_AFULL  24

`define DMA_PERF_CNTR_W 32

`endif

// ==== verilog/dma_pkg.sv ====
// --------------------------------------
// DMA copy engine descriptor and status types
// --------------------------------------
`include "dma_consts.svh"

package dma_pkg;

   // one copy request as pushed by the host
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0]   src_addr;
      logic [`DMA_ADDR_W-1:0]   dst_addr;
      logic [`DMA_LENGTH_W-1:0] length;
   } dma_descriptor_t;

   // bit positions of the one-hot read states
   localparam int IDLE_BIT            = 0;
   localparam int ADDR_PROP_DELAY_BIT = 1;
   localparam int ADDR_SETUP_BIT      = 2;
   localparam int CP_RSP_TO_FIFO_BIT  = 3;
   localparam int WAIT_FOR_WR_RSP_BIT = 4;
   localparam int NUM_RD_STATES       = 5;

   typedef enum logic [NUM_RD_STATES-1:0] {
      IDLE            = NUM_RD_STATES'(1 << IDLE_BIT),
      ADDR_PROP_DELAY = NUM_RD_STATES'(1 << ADDR_PROP_DELAY_BIT),
      ADDR_SETUP      = NUM_RD_STATES'(1 << ADDR_SETUP_BIT),
      CP_RSP_TO_FIFO  = NUM_RD_STATES'(1 << CP_RSP_TO_FIFO_BIT),
      WAIT_FOR_WR_RSP = NUM_RD_STATES'(1 << WAIT_FOR_WR_RSP_BIT)
   } rd_state_t;

   // counts freeze between transfers so they can be read afterwards
   typedef struct packed {
      logic                        busy;
      rd_state_t                   rd_state;
      logic [15:0]                 descriptor_count;
      logic [`DMA_PERF_CNTR_W-1:0] clk_cnt;
      logic [`DMA_PERF_CNTR_W-1:0] valid_cnt;
   } dma_status_t;

endpackage

// ==== verilog/mem_pkg.sv ====
// --------------------------------------
// memory port channel payloads
// --------------------------------------
`include "dma_consts.svh"

package mem_pkg;

   // address channel, shared by ar and aw
   // len is the burst length minus one
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0]      addr;
      logic [`DMA_BURST_LEN_W-1:0] len;
   } mem_req_t;

   // data beat, shared by r and w
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } mem_rsp_t;

endpackage

// ==== verilog/dma_fifo.sv ====
// --------------------------------------
// synchronous FIFO with almost-full flag
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module dma_fifo #(
   parameter int WIDTH = `DMA_DATA_W,
   parameter int DEPTH = `DMA_DATA_DEPTH
) (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] head,
   output logic             not_empty,
   output logic             not_full,
   output logic             almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   // a shallow queue reports almost full only when full
   localparam int AFULL = (`DMA_DATA_AFULL < DEPTH) ? `DMA_DATA_AFULL : DEPTH;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head        = mem[rd_ptr];
   assign not_empty   = (count != '0);
   assign not_full    = (count < CNT_W'(DEPTH));
   assign almost_full = (count >= CNT_W'(AFULL));

   a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
      push |-> not_full);

   a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
      pop |-> not_empty);

endmodule

// ==== verilog/xfer_counters.sv ====
// --------------------------------------
// per-transfer performance and descriptor counts
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module xfer_counters (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 xfer_start,
   input  logic                 beat_accept,
   input  logic                 desc_retire,
   input  logic                 active,
   input  dma_pkg::rd_state_t   rd_state,
   output dma_pkg::dma_status_t status
);

   logic                        busy;
   logic [15:0]                 desc_cnt;
   logic [`DMA_PERF_CNTR_W-1:0] clk_cnt;
   logic [`DMA_PERF_CNTR_W-1:0] valid_cnt;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy      <= 1'b0;
         desc_cnt  <= '0;
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else begin
         busy <= active;
         // a new transfer restarts the bandwidth counts, idle holds them
         if (xfer_start) begin
            clk_cnt   <= '0;
            valid_cnt <= '0;
         end else if (active) begin
            clk_cnt   <= clk_cnt + 1'b1;
            valid_cnt <= valid_cnt + beat_accept;
         end
         if (desc_retire) begin
            desc_cnt <= desc_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      status.busy             = busy;
      status.rd_state         = rd_state;
      status.descriptor_count = desc_cnt;
      status.clk_cnt          = clk_cnt;
      status.valid_cnt        = valid_cnt;
   end

   // retire only comes from a running transfer
   a_retire_in_xfer: assert property (@(posedge clk) disable iff (!reset_n)
      desc_retire |-> active && !xfer_start);

endmodule

// ==== verilog/read_src_fsm.sv ====
// --------------------------------------
// source read FSM, splits descriptors into bursts
// and streams read data into the data FIFO
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module read_src_fsm (
   input  logic                     clk,
   input  logic                     reset_n,
   input  dma_pkg::dma_descriptor_t desc,
   input  logic                     desc_not_empty,
   output logic                     desc_rdack,
   output logic                     ar_valid,
   output mem_pkg::mem_req_t        ar,
   input  logic                     ar_ready,
   input  logic                     r_valid,
   input  mem_pkg::mem_rsp_t        r,
   output logic                     r_ready,
   output logic                     fifo_push,
   output logic [`DMA_DATA_W-1:0]   fifo_data,
   input  logic                     fifo_almost_full,
   input  logic                     wr_done,
   output logic                     xfer_start,
   output logic                     beat_accept,
   output logic                     active,
   output dma_pkg::rd_state_t       rd_state
);

   localparam int BCNT_W = `DMA_LENGTH_W - `DMA_BURST_LEN_W + 1;
   localparam logic [`DMA_ADDR_W-1:0] ADDR_STEP = `DMA_ADDR_W'(2 ** `DMA_BURST_LEN_W);
   localparam logic [`DMA_BURST_LEN_W-1:0] MAX_LEN = '1;

   dma_pkg::rd_state_t state;
   dma_pkg::rd_state_t next;

   logic [2:0]               prop_delay;
   logic [`DMA_LENGTH_W-1:0] len_m1;
   logic [BCNT_W-1:0]        num_bursts;
   logic [BCNT_W-1:0]        rd_req_cnt;
   logic [BCNT_W-1:0]        rlast_cnt;
   logic [BCNT_W-1:0]        outstanding;
   logic [`DMA_ADDR_W-1:0]   ar_addr;
   logic                     ar_done;
   logic                     rd_beat;
   logic                     rlast_valid;

   // burst count is ceil(length / 16)
   assign len_m1      = desc.length - 1'b1;
   assign num_bursts  = BCNT_W'(len_m1[`DMA_LENGTH_W-1:`DMA_BURST_LEN_W]) + 1'b1;
   assign outstanding = rd_req_cnt - rlast_cnt;
   assign ar_done     = ar_valid & ar_ready;
   assign rd_beat     = r_valid & r_ready;
   assign rlast_valid = rd_beat & r.last;

   // only the final burst is short
   always_comb begin
      ar.addr = ar_addr;
      ar.len  = ((rd_req_cnt + 1'b1) < num_bursts) ? MAX_LEN
                                                   : len_m1[`DMA_BURST_LEN_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= dma_pkg::IDLE;
      end else begin
         state <= next;
      end
   end

   always_comb begin
      next = state;
      unique case (1'b1)
         state[dma_pkg::IDLE_BIT]: begin
            if (desc_not_empty) begin
               next = dma_pkg::ADDR_PROP_DELAY;
            end
         end
         state[dma_pkg::ADDR_PROP_DELAY_BIT]: begin
            if (prop_delay[2] && ar_ready && (outstanding < 2)) begin
               next = dma_pkg::ADDR_SETUP;
            end
         end
         state[dma_pkg::ADDR_SETUP_BIT]: begin
            if (ar_done) begin
               if ((rd_req_cnt + 1'b1) < num_bursts) begin
                  next = dma_pkg::ADDR_PROP_DELAY;
               end else begin
                  next = dma_pkg::CP_RSP_TO_FIFO;
               end
            end
         end
         state[dma_pkg::CP_RSP_TO_FIFO_BIT]: begin
            if (rlast_valid && ((rlast_cnt + 1'b1) == num_bursts)) begin
               next = dma_pkg::WAIT_FOR_WR_RSP;
            end
         end
         state[dma_pkg::WAIT_FOR_WR_RSP_BIT]: begin
            if (wr_done) begin
               next = dma_pkg::IDLE;
            end
         end
         default: next = dma_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ar_valid   <= 1'b0;
         fifo_push  <= 1'b0;
         prop_delay <= '0;
         rd_req_cnt <= '0;
         rlast_cnt  <= '0;
      end else begin
         ar_valid  <= next[dma_pkg::ADDR_SETUP_BIT];
         fifo_push <= rd_beat;
         // four cycles before each burst, held at four while stalled
         if (next[dma_pkg::ADDR_PROP_DELAY_BIT]) begin
            prop_delay <= prop_delay[2] ? prop_delay : prop_delay + 1'b1;
         end else begin
            prop_delay <= '0;
         end
         if (next[dma_pkg::IDLE_BIT]) begin
            rd_req_cnt <= '0;
            rlast_cnt  <= '0;
         end else begin
            rd_req_cnt <= rd_req_cnt + ar_done;
            rlast_cnt  <= rlast_cnt + rlast_valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      fifo_data <= r.data;
      if (state[dma_pkg::IDLE_BIT]) begin
         ar_addr <= desc.src_addr;
      end else if (ar_done) begin
         ar_addr <= ar_addr + ADDR_STEP;
      end
   end

   assign r_ready     = !fifo_almost_full;
   assign desc_rdack  = state[dma_pkg::WAIT_FOR_WR_RSP_BIT] & wr_done;
   assign xfer_start  = state[dma_pkg::IDLE_BIT] & desc_not_empty;
   assign beat_accept = rd_beat;
   assign active      = !state[dma_pkg::IDLE_BIT];
   assign rd_state    = state;

   // bursts issued minus bursts completed on r
   a_two_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
      outstanding <= 2);

   a_ar_stable: assert property (@(posedge clk) disable iff (!reset_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

// ==== verilog/write_dst_fsm.sv ====
// --------------------------------------
// destination write FSM, drains the data FIFO
// into write bursts
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module write_dst_fsm (
   input  logic                     clk,
   input  logic                     reset_n,
   input  dma_pkg::dma_descriptor_t desc,
   input  logic                     desc_not_empty,
   output logic                     aw_valid,
   output mem_pkg::mem_req_t        aw,
   input  logic                     aw_ready,
   output logic                     w_valid,
   output mem_pkg::mem_rsp_t        w,
   input  logic                     w_ready,
   input  logic                     b_valid,
   output logic                     b_ready,
   input  logic                     fifo_not_empty,
   input  logic [`DMA_DATA_W-1:0]   fifo_head,
   output logic                     fifo_pop,
   output logic                     wr_done
);

   localparam int BCNT_W = `DMA_LENGTH_W - `DMA_BURST_LEN_W + 1;
   localparam logic [`DMA_ADDR_W-1:0] ADDR_STEP = `DMA_ADDR_W'(2 ** `DMA_BURST_LEN_W);
   localparam logic [`DMA_BURST_LEN_W-1:0] MAX_LEN = '1;

   typedef enum logic [2:0] {IDLE, ADDR, DATA, RESP, DONE} wr_state_t;

   wr_state_t state;
   wr_state_t next;

   logic                        busy;
   logic [BCNT_W-1:0]           burst_cnt;
   logic [`DMA_BURST_LEN_W-1:0] beat_cnt;
   logic [`DMA_LENGTH_W-1:0]    len_m1;
   logic [BCNT_W-1:0]           num_bursts;
   logic                        last_burst;
   logic [`DMA_ADDR_W-1:0]      aw_addr;
   logic                        w_done;

   assign len_m1     = desc.length - 1'b1;
   assign num_bursts = BCNT_W'(len_m1[`DMA_LENGTH_W-1:`DMA_BURST_LEN_W]) + 1'b1;
   assign last_burst = (burst_cnt + 1'b1) >= num_bursts;

   always_comb begin
      aw.addr = aw_addr;
      aw.len  = last_burst ? len_m1[`DMA_BURST_LEN_W-1:0] : MAX_LEN;
      w.data  = fifo_head;
      w.last  = (beat_cnt == aw.len);
   end

   assign aw_valid = (state == ADDR);
   assign w_valid  = (state == DATA) && fifo_not_empty;
   assign w_done   = w_valid & w_ready;
   assign fifo_pop = w_done;
   assign b_ready  = (state == RESP);
   assign wr_done  = (state == DONE);

   always_comb begin
      next = state;
      case (state)
         IDLE: if (desc_not_empty && !busy) next = ADDR;
         ADDR: if (aw_ready) next = DATA;
         DATA: if (w_done && w.last) next = RESP;
         RESP: if (b_valid) next = last_burst ? DONE : ADDR;
         DONE: next = IDLE;
         default: next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state     <= IDLE;
         busy      <= 1'b0;
         burst_cnt <= '0;
         beat_cnt  <= '0;
      end else begin
         state <= next;
         // busy spans one descriptor, up to the retire pulse
         if ((state == IDLE) && (next == ADDR)) begin
            busy      <= 1'b1;
            burst_cnt <= '0;
         end else if (state == DONE) begin
            busy <= 1'b0;
         end else if (b_valid && b_ready) begin
            burst_cnt <= burst_cnt + 1'b1;
         end
         if (state == ADDR) begin
            beat_cnt <= '0;
         end else if (w_done) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         aw_addr <= desc.dst_addr;
      end else if (aw_valid && aw_ready) begin
         aw_addr <= aw_addr + ADDR_STEP;
      end
   end

   a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw));

   a_w_stable: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w));

   // the data phase stays within the burst length, so last falls on beat len
   a_beat_within_len: assert property (@(posedge clk) disable iff (!reset_n)
      (state == DATA) |-> (beat_cnt <= aw.len));

endmodule

// ==== verilog/dma_copy_top.sv ====
// --------------------------------------
// DMA copy engine top level
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module dma_copy_top (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     desc_valid,
   input  dma_pkg::dma_descriptor_t desc,
   output logic                     desc_ready,
   output logic                     ar_valid,
   output mem_pkg::mem_req_t        ar,
   input  logic                     ar_ready,
   input  logic                     r_valid,
   input  mem_pkg::mem_rsp_t        r,
   output logic                     r_ready,
   output logic                     aw_valid,
   output mem_pkg::mem_req_t        aw,
   input  logic                     aw_ready,
   output logic                     w_valid,
   output mem_pkg::mem_rsp_t        w,
   input  logic                     w_ready,
   input  logic                     b_valid,
   output logic                     b_ready,
   output dma_pkg::dma_status_t     status
);

   dma_pkg::dma_descriptor_t desc_head;
   logic                     desc_not_empty;
   logic                     desc_rdack;
   logic                     fifo_push;
   logic [`DMA_DATA_W-1:0]   fifo_data;
   logic                     fifo_almost_full;
   logic                     fifo_not_empty;
   logic [`DMA_DATA_W-1:0]   fifo_head;
   logic                     fifo_pop;
   logic                     wr_done;
   logic                     xfer_start;
   logic                     beat_accept;
   logic                     active;
   dma_pkg::rd_state_t       rd_state;

   dma_fifo #(
      .WIDTH ($bits(dma_pkg::dma_descriptor_t)),
      .DEPTH (`DMA_DESC_DEPTH)
   ) desc_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .push        (desc_valid & desc_ready),
      .push_data   (desc),
      .pop         (desc_rdack),
      .head        (desc_head),
      .not_empty   (desc_not_empty),
      .not_full    (desc_ready),
      .almost_full ()
   );

   dma_fifo #(
      .WIDTH (`DMA_DATA_W),
      .DEPTH (`DMA_DATA_DEPTH)
   ) data_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .push        (fifo_push),
      .push_data   (fifo_data),
      .pop         (fifo_pop),
      .head        (fifo_head),
      .not_empty   (fifo_not_empty),
      .not_full    (),
      .almost_full (fifo_almost_full)
   );

   read_src_fsm u_read_src_fsm (
      .clk              (clk),
      .reset_n          (reset_n),
      .desc             (desc_head),
      .desc_not_empty   (desc_not_empty),
      .desc_rdack       (desc_rdack),
      .ar_valid         (ar_valid),
      .ar               (ar),
      .ar_ready         (ar_ready),
      .r_valid          (r_valid),
      .r                (r),
      .r_ready          (r_ready),
      .fifo_push        (fifo_push),
      .fifo_data        (fifo_data),
      .fifo_almost_full (fifo_almost_full),
      .wr_done          (wr_done),
      .xfer_start       (xfer_start),
      .beat_accept      (beat_accept),
      .active           (active),
      .rd_state         (rd_state)
   );

   write_dst_fsm u_write_dst_fsm (
      .clk            (clk),
      .reset_n        (reset_n),
      .desc           (desc_head),
      .desc_not_empty (desc_not_empty),
      .aw_valid       (aw_valid),
      .aw             (aw),
      .aw_ready       (aw_ready),
      .w_valid        (w_valid),
      .w              (w),
      .w_ready        (w_ready),
      .b_valid        (b_valid),
      .b_ready        (b_ready),
      .fifo_not_empty (fifo_not_empty),
      .fifo_head      (fifo_head),
      .fifo_pop       (fifo_pop),
      .wr_done        (wr_done)
   );

   xfer_counters u_xfer_counters (
      .clk         (clk),
      .reset_n     (reset_n),
      .xfer_start  (xfer_start),
      .beat_accept (beat_accept),
      .desc_retire (desc_rdack),
      .active      (active),
      .rd_state    (rd_state),
      .status      (status)
   );

endmodule

// ==== tests/tb_mem_model.sv ====
// --------------------------------------
// source/destination memory model with
// random stalls on every channel
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module tb_mem_model (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              stall_en,
   input  logic              ar_valid,
   input  mem_pkg::mem_req_t ar,
   output logic              ar_ready,
   output logic              r_valid,
   output mem_pkg::mem_rsp_t r,
   input  logic              r_ready,
   input  logic              aw_valid,
   input  mem_pkg::mem_req_t aw,
   output logic              aw_ready,
   input  logic              w_valid,
   input  mem_pkg::mem_rsp_t w,
   output logic              w_ready,
   output logic              b_valid,
   input  logic              b_ready
);

   logic [31:0]            lfsr;
   mem_pkg::mem_req_t      rd_q[$];
   mem_pkg::mem_req_t      wr_q[$];
   mem_pkg::mem_req_t      ar_log[$];
   mem_pkg::mem_req_t      aw_log[$];
   logic [`DMA_DATA_W-1:0] dst_mem [int];
   int                     rd_beat;
   int                     wr_beat;
   int                     pending_b;
   int                     outstanding;
   int                     max_outstanding;
   int                     proto_errs;
   logic                   r_fire;
   logic                   b_fire;

   // upper half holds the beat address, lower half its inversion
   function automatic logic [`DMA_DATA_W-1:0] source_word(logic [`DMA_ADDR_W-1:0] a);
      logic [31:0] half;
      half = {16'h0, a};
      return {half, ~half};
   endfunction

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per stall bit
   function automatic logic stall_bit();
      logic b;
      b = 1'b0;
      if (stall_en) begin
         b = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
      return b;
   endfunction

   task automatic clear_logs();
      ar_log.delete();
      aw_log.delete();
      dst_mem.delete();
      max_outstanding = 0;
   endtask

   initial begin
      lfsr = 32'h534a;
      ar_ready = 1'b0;
      r_valid = 1'b0;
      r = '0;
      aw_ready = 1'b0;
      w_ready = 1'b0;
      b_valid = 1'b0;
      rd_beat = 0;
      wr_beat = 0;
      pending_b = 0;
      outstanding = 0;
      max_outstanding = 0;
      proto_errs = 0;
      r_fire = 1'b0;
      b_fire = 1'b0;
   end

   // handshake bookkeeping, on the edge where transfers happen
   always @(posedge clk) begin
      if (reset_n) begin
         if (ar_valid && ar_ready) begin
            rd_q.push_back(ar);
            ar_log.push_back(ar);
            outstanding++;
         end
         if (r_valid && r_ready) begin
            r_fire = 1'b1;
            rd_beat++;
            if (r.last) begin
               void'(rd_q.pop_front());
               rd_beat = 0;
               outstanding--;
            end
         end
         if (outstanding > max_outstanding) max_outstanding = outstanding;
         if (aw_valid && aw_ready) begin
            wr_q.push_back(aw);
            aw_log.push_back(aw);
         end
         if (w_valid && w_ready) begin
            if (wr_q.size() == 0) begin
               proto_errs++;
            end else begin
               dst_mem[int'(wr_q[0].addr + `DMA_ADDR_W'(wr_beat))] = w.data;
               if (w.last != (wr_beat == int'(wr_q[0].len))) proto_errs++;
               wr_beat++;
               if (w.last) begin
                  void'(wr_q.pop_front());
                  wr_beat = 0;
                  pending_b++;
               end
            end
         end
         if (b_valid && b_ready) begin
            b_fire = 1'b1;
            pending_b--;
         end
      end
   end

   // outputs change on the falling edge only
   always @(negedge clk) begin
      if (!reset_n) begin
         ar_ready = 1'b0;
         aw_ready = 1'b0;
         w_ready = 1'b0;
         r_valid = 1'b0;
         b_valid = 1'b0;
      end else begin
         ar_ready = !stall_bit();
         aw_ready = !stall_bit();
         w_ready = !stall_bit();
         // a raised valid holds its payload until taken
         if (!r_valid || r_fire) begin
            if (rd_q.size() > 0 && !stall_bit()) begin
               r_valid = 1'b1;
               r.data = source_word(rd_q[0].addr + `DMA_ADDR_W'(rd_beat));
               r.last = (rd_beat == int'(rd_q[0].len));
            end else begin
               r_valid = 1'b0;
            end
         end
         r_fire = 1'b0;
         if (!b_valid || b_fire) begin
            b_valid = (pending_b > 0) && !stall_bit();
         end
         b_fire = 1'b0;
      end
   end

endmodule

// ==== tests/tb_dma_copy.sv ====
// --------------------------------------
// DMA copy engine testbench, directed copies
// --------------------------------------
`timescale 1ns/10ps
`include "dma_consts.svh"

module tb_dma_copy;

   localparam int TIMEOUT = 5000;

   logic                     clk;
   logic                     reset_n;
   logic                     stall_en;
   logic                     desc_valid;
   dma_pkg::dma_descriptor_t desc;
   logic                     desc_ready;
   logic                     ar_valid;
   mem_pkg::mem_req_t        ar;
   logic                     ar_ready;
   logic                     r_valid;
   mem_pkg::mem_rsp_t        r;
   logic                     r_ready;
   logic                     aw_valid;
   mem_pkg::mem_req_t        aw;
   logic                     aw_ready;
   logic                     w_valid;
   mem_pkg::mem_rsp_t        w;
   logic                     w_ready;
   logic                     b_valid;
   logic                     b_ready;
   dma_pkg::dma_status_t     status;

   int mismatch_cnt;
   int fail_cnt;
   int desc_total;

   dma_copy_top dut (.*);

   tb_mem_model mem (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [`DMA_DATA_W-1:0] expected_word(logic [`DMA_ADDR_W-1:0] a);
      logic [31:0] half;
      half = {16'h0, a};
      return {half, ~half};
   endfunction

   // burst k of a copy: full 16-beat bursts, the remainder last
   function automatic mem_pkg::mem_req_t burst_req(logic [15:0] base, int len, int k);
      mem_pkg::mem_req_t q;
      q.addr = base + 16'(16 * k);
      q.len = (k < (len + 15) / 16 - 1) ? 4'hf : 4'((len - 1) % 16);
      return q;
   endfunction

   task automatic compare_data(string name, logic [`DMA_DATA_W-1:0] got, exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic compare_req(string name, mem_pkg::mem_req_t got, exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic compare_status(string name, dma_pkg::dma_status_t got, exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic apply_reset();
      reset_n = 1'b0;
      repeat (8) @(negedge clk);
      reset_n = 1'b1;
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic push_desc(logic [15:0] src, logic [15:0] dst, int len);
      int t;
      desc_valid = 1'b1;
      desc.src_addr = src;
      desc.dst_addr = dst;
      desc.length = 12'(len);
      t = 0;
      while (!desc_ready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!desc_ready) begin
         $display("timeout: descriptor queue never accepted a push");
         fail_cnt++;
      end
      @(negedge clk);
      desc_valid = 1'b0;
   endtask

   task automatic wait_desc_count(int target);
      int t;
      t = 0;
      while (int'(status.descriptor_count) != target && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (int'(status.descriptor_count) != target) begin
         $display("timeout: descriptor count never reached %0d", target);
         fail_cnt++;
      end
   endtask

   task automatic check_copy(logic [15:0] src, dst, int len, int ar_first, int aw_first);
      int nb;
      nb = (len + 15) / 16;
      if (mem.ar_log.size() < ar_first + nb || mem.aw_log.size() < aw_first + nb) begin
         $display("too few bursts seen for the copy to %h", dst);
         fail_cnt++;
      end else begin
         for (int k = 0; k < nb; k++) begin
            compare_req("ar", mem.ar_log[ar_first + k], burst_req(src, len, k));
            compare_req("aw", mem.aw_log[aw_first + k], burst_req(dst, len, k));
         end
      end
      for (int i = 0; i < len; i++) begin
         if (!mem.dst_mem.exists(int'(dst + 16'(i)))) begin
            $display("no write arrived at destination beat %h", dst + 16'(i));
            fail_cnt++;
         end else begin
            compare_data("dst_mem", mem.dst_mem[int'(dst + 16'(i))], expected_word(src + 16'(i)));
         end
      end
   endtask

   task automatic run_copy(logic [15:0] src, dst, int len);
      mem.clear_logs();
      push_desc(src, dst, len);
      desc_total++;
      wait_desc_count(desc_total);
      check_copy(src, dst, len, 0, 0);
      if (mem.aw_log.size() != (len + 15) / 16) begin
         $display("copy of %0d beats used %0d write bursts", len, mem.aw_log.size());
         fail_cnt++;
      end
   endtask

   task automatic test_reset();
      dma_pkg::dma_status_t exp;
      exp = '0;
      exp.rd_state = dma_pkg::IDLE;
      compare_status("status", status, exp);
      repeat (20) begin
         @(negedge clk);
         if (ar_valid || aw_valid || w_valid) begin
            $display("a request channel went valid with no descriptor queued");
            fail_cnt++;
         end
      end
   endtask

   task automatic test_back_pressure();
      stall_en = 1'b1;
      run_copy(16'h0300, 16'h6000, 64);
      if (mem.max_outstanding > 2) begin
         $display("%0d read bursts were outstanding at once", mem.max_outstanding);
         fail_cnt++;
      end
      stall_en = 1'b0;
   endtask

   task automatic test_queued();
      mem.clear_logs();
      push_desc(16'h0400, 16'h7000, 10);
      push_desc(16'h0500, 16'h7100, 17);
      push_desc(16'h0600, 16'h7200, 33);
      desc_total += 3;
      wait_desc_count(desc_total);
      // log order shows the descriptors ran in order
      check_copy(16'h0400, 16'h7000, 10, 0, 0);
      check_copy(16'h0500, 16'h7100, 17, 1, 1);
      check_copy(16'h0600, 16'h7200, 33, 3, 3);
   endtask

   task automatic test_status_counters();
      dma_pkg::dma_status_t snap;
      dma_pkg::dma_status_t exp;
      int t;
      run_copy(16'h0800, 16'h8000, 20);
      t = 0;
      while (status.busy && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      snap = status;
      exp = snap;
      exp.busy = 1'b0;
      exp.rd_state = dma_pkg::IDLE;
      exp.descriptor_count = 16'(desc_total);
      exp.valid_cnt = 20;
      compare_status("status", snap, exp);
      if (snap.clk_cnt < 20) begin
         $display("clock count %0d is below the 20 beats copied", snap.clk_cnt);
         fail_cnt++;
      end
      repeat (10) @(negedge clk);
      compare_status("status_idle", status, snap);
   endtask

   initial begin
      reset_n = 1'b0;
      stall_en = 1'b0;
      desc_valid = 1'b0;
      desc = '0;
      mismatch_cnt = 0;
      fail_cnt = 0;
      desc_total = 0;
      apply_reset();
      test_reset();
      run_copy(16'h0100, 16'h4000, 5);
      run_copy(16'h0200, 16'h5000, 40);
      test_back_pressure();
      test_queued();
      test_status_counters();
      if (mem.proto_errs != 0) begin
         $display("%0d write beats had a wrong last flag or no open burst", mem.proto_errs);
         fail_cnt++;
      end
      $display("run complete: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/dma_pkg.sv
verilog/mem_pkg.sv
verilog/dma_fifo.sv
verilog/xfer_counters.sv
verilog/read_src_fsm.sv
verilog/write_dst_fsm.sv
verilog/dma_copy_top.sv
tests/tb_mem_model.sv
tests/tb_dma_copy.sv

// ==== Bender.yml ====
package:
  name: dma_copy

export_include_dirs:
  - include

sources:
  - verilog/dma_pkg.sv
  - verilog/mem_pkg.sv
  - verilog/dma_fifo.sv
  - verilog/xfer_counters.sv
  - verilog/read_src_fsm.sv
  - verilog/write_dst_fsm.sv
  - verilog/dma_copy_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_dma_copy.sv
